/* dispatch_stage.f */
+incdir+include
hw/dispatch_pkg.sv
hw/arch_reg_file.sv
hw/reorder_buffer.sv
hw/operand_fetch.sv
hw/reservation_station.sv
hw/dispatch_stage.sv
dv/tb_dispatch_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dispatch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_dispatch_stage \
    -f dispatch_stage.f \
    --Mdir obj_dir -o sim_dispatch_stage

./obj_dir/sim_dispatch_stage | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* dv/tb_dispatch_stage.sv */
`timescale 1ns/1ps

`include "dispatch_params.svh"

module tb_dispatch_stage;

    localparam int CLK_NS      = 40;
    localparam int TEST_CYCLES = 1500;                      // Sum over all tests, rounded up
    localparam int WATCHDOG_NS = TEST_CYCLES * CLK_NS * 2;
    localparam int NL          = `NUM_LANES;

    logic clk_i;
    logic arst_n_i;
    dispatch_pkg::dispatch_req_t [NL-1:0] dispatch_i;
    logic                        [NL-1:0] dispatch_ready_o;
    dispatch_pkg::exec_req_t     [NL-1:0] issue_o;
    logic                        [NL-1:0] issue_ready_i;
    dispatch_pkg::cdb_t          [NL-1:0] cdb_i;
    dispatch_pkg::commit_t       [NL-1:0] commit_o;

    dispatch_stage dut (.*);

    // ==================================================
    // Clock, LFSR, checks
    // ==================================================
    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS/2) clk_i = ~clk_i;
    end

    int          errors = 0;
    logic [31:0] lfsr_q = 32'h7c0e_b237;
    logic        mon_on = 1'b0;
    dispatch_pkg::rob_idx_t rob_next = '0;      // Issue-stage allocation pointer

    // Taps 32, 22, 2, 1; one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        #2;                                     // Drive point
    endtask

    task automatic clear_inputs();
        dispatch_i = '0;
        cdb_i      = '0;
    endtask

    function automatic dispatch_pkg::rob_idx_t alloc_rob();
        dispatch_pkg::rob_idx_t idx;
        idx      = rob_next;
        rob_next = rob_next + 1'b1;
        return idx;
    endfunction

    function automatic dispatch_pkg::dispatch_req_t make_req(
        input logic [3:0] op, input logic use_imm, input logic [31:0] imm,
        input logic [5:0] src_a, input logic [5:0] src_b,
        input logic [4:0] rd_rob, input logic [4:0] rd_arch
    );
        dispatch_pkg::dispatch_req_t r;
        r.valid   = 1'b1;
        r.alu_op  = op;
        r.use_imm = use_imm;
        r.imm     = imm;
        r.src_a   = src_a;
        r.src_b   = src_b;
        r.rd_rob  = rd_rob;
        r.rd_arch = rd_arch;
        return r;
    endfunction

    // ==================================================
    // ROB and register file model, commit monitor
    // ==================================================
    logic [31:0] m_rf   [32];
    logic [31:0] m_data [32];
    logic [4:0]  m_arch [32];
    logic [31:0] m_busy;
    logic [31:0] m_done;
    logic [4:0]  m_head;
    logic [NL-1:0]                        seen_fire;
    dispatch_pkg::dispatch_req_t [NL-1:0] seen_req;
    dispatch_pkg::cdb_t          [NL-1:0] seen_cdb;

    always @(negedge clk_i) begin               // Mid-cycle, inputs settled
        for (int l = 0; l < NL; l++) begin
            seen_fire[l] = mon_on && dispatch_i[l].valid && dispatch_ready_o[l];
            seen_req[l]  = dispatch_i[l];
            seen_cdb[l]  = mon_on ? cdb_i[l] : '0;
        end
    end

    always @(posedge clk_i) begin
        logic       run;
        logic [4:0] idx;
        logic [4:0] new_head;
        if (mon_on) begin
            run      = 1'b1;
            new_head = m_head;
            for (int k = 0; k < NL; k++) begin   // Retire window seen before the edge
                idx = m_head + 5'(k);
                run = run && m_busy[idx] && m_done[idx];
                if (run) begin
                    m_busy[idx] = 1'b0;
                    if (m_arch[idx] != '0) m_rf[m_arch[idx]] = m_data[idx];
                    new_head = idx + 1'b1;
                end
            end
            m_head = new_head;
            for (int k = 0; k < NL; k++) begin
                if (seen_cdb[k].valid) begin
                    m_done[seen_cdb[k].rob_idx] = 1'b1;
                    m_data[seen_cdb[k].rob_idx] = seen_cdb[k].data;
                end
                if (seen_fire[k]) begin
                    m_busy[seen_req[k].rd_rob] = 1'b1;
                    m_done[seen_req[k].rd_rob] = 1'b0;
                    m_arch[seen_req[k].rd_rob] = seen_req[k].rd_arch;
                end
            end
            #1;
            run = 1'b1;
            for (int k = 0; k < NL; k++) begin
                idx = m_head + 5'(k);
                run = run && m_busy[idx] && m_done[idx];
                expect_eq("commit valid", 32'(run), 32'(commit_o[k].valid));
                if (run) begin
                    expect_eq("commit rob_idx", 32'(idx), 32'(commit_o[k].rob_idx));
                    expect_eq("commit rd_arch", 32'(m_arch[idx]), 32'(commit_o[k].rd_arch));
                    expect_eq("commit data", m_data[idx], commit_o[k].data);
                end
            end
        end
    end

    // ==================================================
    // Tests
    // ==================================================
    task automatic check_reset_state();
        for (int l = 0; l < NL; l++) begin
            expect_eq("reset issue valid", 32'd0, 32'(issue_o[l].valid));
            expect_eq("reset commit valid", 32'd0, 32'(commit_o[l].valid));
            expect_eq("reset dispatch ready", 32'd1, 32'(dispatch_ready_o[l]));
        end
    endtask

    task automatic issue_immediate();
        logic [4:0]  r;
        logic [31:0] imm;
        r   = alloc_rob();
        imm = lfsr_bits(32);
        dispatch_i[0] = make_req(4'h6, 1'b1, imm, 6'd0, 6'd0, r, 5'd5);
        step();
        clear_inputs();
        expect_eq("imm valid", 32'd1, 32'(issue_o[0].valid));
        expect_eq("imm op_a", 32'd0, issue_o[0].op_a);
        expect_eq("imm op_b", imm, issue_o[0].op_b);
        expect_eq("imm rob_idx", 32'(r), 32'(issue_o[0].rob_idx));
        expect_eq("imm alu_op", 32'h6, 32'(issue_o[0].alu_op));
        cdb_i[0] = '{valid: 1'b1, rob_idx: r, data: lfsr_bits(32)};
        step();
        clear_inputs();
        step();
    endtask

    task automatic wake_from_cdb();
        logic [4:0]  p, c;
        logic [31:0] d, imm;
        p = alloc_rob();
        dispatch_i[0] = make_req(4'h1, 1'b1, 32'h11, 6'd0, 6'd0, p, 5'd9);
        step();
        clear_inputs();
        c   = alloc_rob();
        imm = lfsr_bits(32);
        dispatch_i[1] = make_req(4'h2, 1'b1, imm, {1'b1, p}, 6'd0, c, 5'd10);
        step();
        clear_inputs();
        expect_eq("wake early", 32'd0, 32'(issue_o[1].valid));
        step();
        expect_eq("wake early", 32'd0, 32'(issue_o[1].valid));
        d = lfsr_bits(32);
        cdb_i[0] = '{valid: 1'b1, rob_idx: p, data: d};
        step();
        clear_inputs();
        expect_eq("wake valid", 32'd1, 32'(issue_o[1].valid));
        expect_eq("wake op_a", d, issue_o[1].op_a);
        expect_eq("wake op_b", imm, issue_o[1].op_b);
        expect_eq("wake rob_idx", 32'(c), 32'(issue_o[1].rob_idx));
        cdb_i[1] = '{valid: 1'b1, rob_idx: c, data: lfsr_bits(32)};
        step();
        clear_inputs();
        // Strobe in the dispatch cycle itself
        p = alloc_rob();
        dispatch_i[0] = make_req(4'h1, 1'b1, 32'h22, 6'd0, 6'd0, p, 5'd11);
        step();
        clear_inputs();
        c = alloc_rob();
        d = lfsr_bits(32);
        dispatch_i[2] = make_req(4'h3, 1'b0, 32'h0, 6'd0, {1'b1, p}, c, 5'd12);
        cdb_i[0]      = '{valid: 1'b1, rob_idx: p, data: d};
        step();
        clear_inputs();
        expect_eq("same-cycle valid", 32'd1, 32'(issue_o[2].valid));
        expect_eq("same-cycle op_a", 32'd0, issue_o[2].op_a);
        expect_eq("same-cycle op_b", d, issue_o[2].op_b);
        cdb_i[2] = '{valid: 1'b1, rob_idx: c, data: lfsr_bits(32)};
        step();
        clear_inputs();
        step();
    endtask

    task automatic commit_in_order();
        logic [4:0]  r [3];
        logic [31:0] d [3];
        logic [4:0]  arch [3];
        arch = '{5'd3, 5'd7, 5'd0};
        for (int l = 0; l < NL; l++) begin
            r[l] = alloc_rob();
            d[l] = lfsr_bits(32);
            dispatch_i[l] = make_req(4'h4, 1'b1, 32'h5, 6'd0, 6'd0, r[l], arch[l]);
        end
        step();
        clear_inputs();
        for (int l = NL-1; l >= 0; l--) begin   // Youngest result first
            cdb_i[l] = '{valid: 1'b1, rob_idx: r[l], data: d[l]};
            step();
            clear_inputs();
            for (int k = 0; k < NL; k++) begin
                expect_eq("order valid", 32'(l == 0), 32'(commit_o[k].valid));
                if (l == 0) begin
                    expect_eq("order rob_idx", 32'(r[k]), 32'(commit_o[k].rob_idx));
                    expect_eq("order rd_arch", 32'(arch[k]), 32'(commit_o[k].rd_arch));
                    expect_eq("order data", d[k], commit_o[k].data);
                end
            end
        end
        step();
        r[0] = alloc_rob();
        r[1] = alloc_rob();
        dispatch_i[0] = make_req(4'h0, 1'b0, 32'h0, 6'd3, 6'd7, r[0], 5'd1);
        dispatch_i[1] = make_req(4'h0, 1'b0, 32'h0, 6'd0, 6'd3, r[1], 5'd2);
        step();
        clear_inputs();
        expect_eq("rf x3", d[0], issue_o[0].op_a);
        expect_eq("rf x7", d[1], issue_o[0].op_b);
        expect_eq("rf x0", 32'd0, issue_o[1].op_a);
        expect_eq("rf x3 lane1", d[0], issue_o[1].op_b);
        cdb_i[0] = '{valid: 1'b1, rob_idx: r[0], data: lfsr_bits(32)};
        cdb_i[1] = '{valid: 1'b1, rob_idx: r[1], data: lfsr_bits(32)};
        step();
        clear_inputs();
        step();
    endtask

    task automatic hold_under_backpressure();
        logic [4:0] a, b;
        issue_ready_i[1] = 1'b0;
        a = alloc_rob();
        dispatch_i[1] = make_req(4'h7, 1'b1, 32'hA, 6'd0, 6'd0, a, 5'd13);
        step();
        clear_inputs();
        expect_eq("bp ready one", 32'd1, 32'(dispatch_ready_o[1]));
        b = alloc_rob();
        dispatch_i[1] = make_req(4'h8, 1'b1, 32'hB, 6'd0, 6'd0, b, 5'd14);
        step();
        clear_inputs();
        expect_eq("bp ready full", 32'd0, 32'(dispatch_ready_o[1]));
        step();
        expect_eq("bp hold valid", 32'd1, 32'(issue_o[1].valid));
        expect_eq("bp hold rob_idx", 32'(a), 32'(issue_o[1].rob_idx));
        issue_ready_i[1] = 1'b1;
        step();
        expect_eq("bp second valid", 32'd1, 32'(issue_o[1].valid));
        expect_eq("bp second rob_idx", 32'(b), 32'(issue_o[1].rob_idx));
        step();
        expect_eq("bp drained", 32'd0, 32'(issue_o[1].valid));
        expect_eq("bp ready again", 32'd1, 32'(dispatch_ready_o[1]));
        cdb_i[1] = '{valid: 1'b1, rob_idx: a, data: lfsr_bits(32)};
        step();
        cdb_i[1] = '{valid: 1'b1, rob_idx: b, data: lfsr_bits(32)};
        step();
        clear_inputs();
        step();
    endtask

    task automatic random_traffic(input int iters);
        logic [4:0]  prev [3];
        logic [4:0]  done_rob [3];
        logic [3:0]  exp_op [3];
        logic [31:0] exp_a [3];
        logic [31:0] exp_b [3];
        logic [5:0]  src [2];
        logic [4:0]  r, pick;
        logic        imm_sel;
        logic [31:0] imm;
        for (int it = 0; it < iters; it++) begin
            done_rob = prev;                    // Last bundle, already completed
            for (int l = 0; l < NL; l++) begin
                for (int s = 0; s < 2; s++) begin
                    pick = 5'(lfsr_bits(5));
                    if (it > 0 && lfsr_bits(1) == 32'd1) begin  // Done ROB entry
                        src[s] = {1'b1, done_rob[pick % 3]};
                        if (s == 0) exp_a[l] = m_data[done_rob[pick % 3]];
                        else exp_b[l] = m_data[done_rob[pick % 3]];
                    end else begin
                        src[s] = {1'b0, pick};
                        if (s == 0) exp_a[l] = m_rf[pick];
                        else exp_b[l] = m_rf[pick];
                    end
                end
                imm_sel = lfsr_bits(1) == 32'd1;
                imm     = lfsr_bits(32);
                if (imm_sel) exp_b[l] = imm;
                exp_op[l] = 4'(lfsr_bits(4));
                r = alloc_rob();
                dispatch_i[l] = make_req(exp_op[l], imm_sel, imm, src[0], src[1],
                                         r, 5'(lfsr_bits(5)));
                prev[l] = r;
            end
            step();
            clear_inputs();
            for (int l = 0; l < NL; l++) begin
                expect_eq("rand valid", 32'd1, 32'(issue_o[l].valid));
                expect_eq("rand rob_idx", 32'(prev[l]), 32'(issue_o[l].rob_idx));
                expect_eq("rand alu_op", 32'(exp_op[l]), 32'(issue_o[l].alu_op));
                expect_eq("rand op_a", exp_a[l], issue_o[l].op_a);
                expect_eq("rand op_b", exp_b[l], issue_o[l].op_b);
                cdb_i[l] = '{valid: 1'b1, rob_idx: prev[l], data: lfsr_bits(32)};
            end
            step();
            clear_inputs();
            step();
        end
    endtask

    // ==================================================
    // Sequence and watchdog
    // ==================================================
    initial begin
        arst_n_i      = 1'b0;
        issue_ready_i = '1;
        clear_inputs();
        for (int i = 0; i < 32; i++) begin
            m_rf[i]   = '0;
            m_data[i] = '0;
            m_arch[i] = '0;
        end
        m_busy = '0;
        m_done = '0;
        m_head = '0;
        repeat (5) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        mon_on   = 1'b1;
        check_reset_state();
        issue_immediate();
        wake_from_cdb();
        commit_in_order();
        hold_under_backpressure();
        random_traffic(40);
        repeat (3) step();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* hw/dispatch_stage.sv */
`timescale 1ns/1ps

`include "dispatch_params.svh"

module dispatch_stage (
    input  logic                                            clk_i,
    input  logic                                            arst_n_i,
    // Issue stage
    input  dispatch_pkg::dispatch_req_t [`NUM_LANES-1:0]    dispatch_i,
    output logic                        [`NUM_LANES-1:0]    dispatch_ready_o,
    // Functional units
    output dispatch_pkg::exec_req_t     [`NUM_LANES-1:0]    issue_o,
    input  logic                        [`NUM_LANES-1:0]    issue_ready_i,
    input  dispatch_pkg::cdb_t          [`NUM_LANES-1:0]    cdb_i,
    // Retirement
    output dispatch_pkg::commit_t       [`NUM_LANES-1:0]    commit_o
);

    logic                   [`NUM_LANES-1:0]   fire;        // Lane accepted this cycle
    dispatch_pkg::rob_idx_t [2*`NUM_LANES-1:0] rob_rd_idx;
    dispatch_pkg::operand_t [2*`NUM_LANES-1:0] rob_rd;
    dispatch_pkg::operand_t [`NUM_LANES-1:0]   op_a;
    dispatch_pkg::operand_t [`NUM_LANES-1:0]   op_b;

    operand_fetch u_operand_fetch (
        .dispatch_i   (dispatch_i),
        .rob_rd_idx_o (rob_rd_idx),
        .rob_rd_i     (rob_rd),
        .commit_i     (commit_o),       // Register file write ports
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .op_a_o       (op_a),
        .op_b_o       (op_b)
    );

    reorder_buffer u_rob (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .alloc_i      (dispatch_i),
        .alloc_fire_i (fire),
        .cdb_i        (cdb_i),
        .rob_rd_idx_i (rob_rd_idx),
        .rob_rd_o     (rob_rd),
        .commit_o     (commit_o)
    );

    // ==================================================
    // One station per lane
    // ==================================================
    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
        assign fire[l] = dispatch_i[l].valid & dispatch_ready_o[l];

        reservation_station #(
            .LANE_ID (l)
        ) u_rs (
            .clk_i         (clk_i),
            .arst_n_i      (arst_n_i),
            .req_i         (dispatch_i[l]),
            .op_a_i        (op_a[l]),
            .op_b_i        (op_b[l]),
            .ready_o       (dispatch_ready_o[l]),
            .cdb_i         (cdb_i),         // All channels snooped
            .issue_o       (issue_o[l]),
            .issue_ready_i (issue_ready_i[l])
        );
    end

endmodule

/* hw/reservation_station.sv */
`timescale 1ns/1ps

`include "dispatch_params.svh"

module reservation_station #(
    parameter int LANE_ID = 0
) (
    input  logic                                    clk_i,
    input  logic                                    arst_n_i,
    input  dispatch_pkg::dispatch_req_t             req_i,
    input  dispatch_pkg::operand_t                  op_a_i,
    input  dispatch_pkg::operand_t                  op_b_i,
    output logic                                    ready_o,
    input  dispatch_pkg::cdb_t [`NUM_LANES-1:0]     cdb_i,
    output dispatch_pkg::exec_req_t                 issue_o,
    input  logic                                    issue_ready_i
);

    localparam int SLOT_W = $clog2(`RS_DEPTH);

    // ==================================================
    // Entries and issue register
    // ==================================================
    dispatch_pkg::rs_state_e st_q  [`RS_DEPTH];
    dispatch_pkg::rs_state_e st_d  [`RS_DEPTH];
    dispatch_pkg::rs_entry_t ent_q [`RS_DEPTH];
    dispatch_pkg::rs_entry_t ent_d [`RS_DEPTH];

    logic [SLOT_W-1:0]       old_q, old_d;      // Older entry, two-entry age bit
    logic [SLOT_W-1:0]       slot_q, slot_d;    // Entry shown on issue_o
    logic [SLOT_W-1:0]       free_slot;
    logic [SLOT_W-1:0]       pick;
    logic                    accept;
    dispatch_pkg::exec_req_t iss_q, iss_d;

    // Wake a pending operand from its producer's CDB channel
    function automatic dispatch_pkg::operand_t snoop(
        input dispatch_pkg::operand_t op,
        input dispatch_pkg::rob_idx_t idx
    );
        dispatch_pkg::operand_t res;
        res = op;
        for (int k = 0; k < `NUM_LANES; k++) begin
            if (op.tag == dispatch_pkg::tag_t'(k) && cdb_i[k].valid && cdb_i[k].rob_idx == idx) begin
                res.tag  = `TAG_READY;
                res.data = cdb_i[k].data;
            end
        end
        return res;
    endfunction

    // Lowest free entry
    always_comb begin
        ready_o   = 1'b0;
        free_slot = '0;
        for (int i = `RS_DEPTH-1; i >= 0; i--) begin
            if (st_q[i] == dispatch_pkg::FREE) begin
                ready_o   = 1'b1;
                free_slot = SLOT_W'(i);
            end
        end
    end

    assign accept = req_i.valid && ready_o;

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        st_d   = st_q;
        ent_d  = ent_q;
        old_d  = old_q;
        slot_d = slot_q;
        iss_d  = iss_q;
        pick   = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (st_q[i] != dispatch_pkg::FREE) begin
                ent_d[i].a = snoop(ent_q[i].a, ent_q[i].wait_a);
                ent_d[i].b = snoop(ent_q[i].b, ent_q[i].wait_b);
            end
        end
        if (iss_q.valid && issue_ready_i) begin
            st_d[slot_q] = dispatch_pkg::FREE;          // Handshake done
        end
        if (st_d[old_q] == dispatch_pkg::FREE) begin
            old_d = ~old_q;
        end
        if (accept) begin
            ent_d[free_slot].alu_op  = req_i.alu_op;
            ent_d[free_slot].rob_idx = req_i.rd_rob;
            ent_d[free_slot].wait_a  = req_i.src_a[`ROB_IDX_W-1:0];
            ent_d[free_slot].wait_b  = req_i.src_b[`ROB_IDX_W-1:0];
            ent_d[free_slot].a = snoop(op_a_i, req_i.src_a[`ROB_IDX_W-1:0]);   // Same-cycle CDB
            ent_d[free_slot].b = snoop(op_b_i, req_i.src_b[`ROB_IDX_W-1:0]);
            st_d[free_slot]    = dispatch_pkg::WAIT;
            old_d = (st_d[~free_slot] == dispatch_pkg::FREE) ? free_slot : ~free_slot;
        end
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (st_d[i] != dispatch_pkg::FREE) begin
                st_d[i] = (ent_d[i].a.tag == `TAG_READY && ent_d[i].b.tag == `TAG_READY) ?
                          dispatch_pkg::READY : dispatch_pkg::WAIT;
            end
        end
        // Refill issue register, oldest ready first
        if (!iss_q.valid || issue_ready_i) begin
            iss_d.valid = 1'b0;
            pick = (st_d[old_d] == dispatch_pkg::READY) ? old_d : ~old_d;
            if (st_d[pick] == dispatch_pkg::READY) begin
                iss_d.valid   = 1'b1;
                iss_d.alu_op  = ent_d[pick].alu_op;
                iss_d.op_a    = ent_d[pick].a.data;
                iss_d.op_b    = ent_d[pick].b.data;
                iss_d.rob_idx = ent_d[pick].rob_idx;
                slot_d        = pick;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                st_q[i] <= dispatch_pkg::FREE;
            end
            old_q       <= '0;
            slot_q      <= '0;
            iss_q.valid <= 1'b0;
        end else begin
            st_q   <= st_d;
            old_q  <= old_d;
            slot_q <= slot_d;
            iss_q  <= iss_d;
        end
    end

    always_ff @(posedge clk_i) begin
        ent_q <= ent_d;
    end

    assign issue_o = iss_q;

    // Held issue always comes from a fully woken entry
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        iss_q.valid |-> (ent_q[slot_q].a.tag == `TAG_READY && ent_q[slot_q].b.tag == `TAG_READY))
        else $error("RS lane %0d issued ROB %0d with a pending operand", LANE_ID, iss_q.rob_idx);

endmodule

/* hw/operand_fetch.sv */
`timescale 1ns/1ps

`include "dispatch_params.svh"

module operand_fetch (
    input  dispatch_pkg::dispatch_req_t [`NUM_LANES-1:0]    dispatch_i,
    output dispatch_pkg::rob_idx_t      [2*`NUM_LANES-1:0]  rob_rd_idx_o,
    input  dispatch_pkg::operand_t      [2*`NUM_LANES-1:0]  rob_rd_i,
    input  dispatch_pkg::commit_t       [`NUM_LANES-1:0]    commit_i,
    input  logic                                            clk_i,
    input  logic                                            arst_n_i,
    output dispatch_pkg::operand_t      [`NUM_LANES-1:0]    op_a_o,
    output dispatch_pkg::operand_t      [`NUM_LANES-1:0]    op_b_o
);

    dispatch_pkg::arch_addr_t [2*`NUM_LANES-1:0] rf_addr;
    dispatch_pkg::data_t      [2*`NUM_LANES-1:0] rf_data;

    arch_reg_file u_arch_reg_file (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .rd_addr_i (rf_addr),
        .rd_data_o (rf_data),
        .wr_i      (commit_i)       // Retired results
    );

    // ROB result when the MSB is set, else committed register value
    function automatic dispatch_pkg::operand_t resolve(
        input dispatch_pkg::phys_addr_t src,
        input dispatch_pkg::operand_t   rob,
        input dispatch_pkg::data_t      rf
    );
        dispatch_pkg::operand_t op;
        if (src[`ROB_IDX_W]) begin
            op = rob;
        end else begin
            op.tag  = `TAG_READY;
            op.data = rf;
        end
        return op;
    endfunction

    always_comb begin
        for (int l = 0; l < `NUM_LANES; l++) begin
            rf_addr[2*l]        = dispatch_i[l].src_a[`ARCH_ADDR_W-1:0];
            rf_addr[2*l+1]      = dispatch_i[l].src_b[`ARCH_ADDR_W-1:0];
            rob_rd_idx_o[2*l]   = dispatch_i[l].src_a[`ROB_IDX_W-1:0];
            rob_rd_idx_o[2*l+1] = dispatch_i[l].src_b[`ROB_IDX_W-1:0];
            op_a_o[l] = resolve(dispatch_i[l].src_a, rob_rd_i[2*l], rf_data[2*l]);
            op_b_o[l] = resolve(dispatch_i[l].src_b, rob_rd_i[2*l+1], rf_data[2*l+1]);
            if (dispatch_i[l].use_imm) begin
                op_b_o[l].tag  = `TAG_READY;    // Immediate never waits
                op_b_o[l].data = dispatch_i[l].imm;
            end
        end
    end

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps

`include "dispatch_params.svh"

module reorder_buffer (
    input  logic                                            clk_i,
    input  logic                                            arst_n_i,
    // Allocation by accepted lanes
    input  dispatch_pkg::dispatch_req_t [`NUM_LANES-1:0]    alloc_i,
    input  logic                        [`NUM_LANES-1:0]    alloc_fire_i,
    // Completion
    input  dispatch_pkg::cdb_t          [`NUM_LANES-1:0]    cdb_i,
    // Operand reads, A and B per lane
    input  dispatch_pkg::rob_idx_t      [2*`NUM_LANES-1:0]  rob_rd_idx_i,
    output dispatch_pkg::operand_t      [2*`NUM_LANES-1:0]  rob_rd_o,
    // In-order retirement
    output dispatch_pkg::commit_t       [`NUM_LANES-1:0]    commit_o
);

    // ==================================================
    // Entry state
    // ==================================================
    logic [`ROB_DEPTH-1:0]  busy_q;     // Allocated and not retired
    logic [`ROB_DEPTH-1:0]  done_q;     // Result written by the CDB
    dispatch_pkg::rob_idx_t head_q;     // Oldest entry

    dispatch_pkg::arch_addr_t arch_q [`ROB_DEPTH];
    dispatch_pkg::tag_t       prod_q [`ROB_DEPTH];  // Lane that produces the result
    dispatch_pkg::data_t      data_q [`ROB_DEPTH];

    // ==================================================
    // Operand read ports
    // ==================================================
    always_comb begin
        dispatch_pkg::rob_idx_t idx;
        for (int p = 0; p < 2*`NUM_LANES; p++) begin
            idx              = rob_rd_idx_i[p];
            rob_rd_o[p].data = data_q[idx];
            rob_rd_o[p].tag  = done_q[idx] ? `TAG_READY : prod_q[idx];
            // Producer in an older lane of this same bundle
            for (int l = 0; l < p / 2; l++) begin
                if (alloc_fire_i[l] && alloc_i[l].rd_rob == idx) begin
                    rob_rd_o[p].tag = dispatch_pkg::tag_t'(l);
                end
            end
        end
    end

    // ==================================================
    // Commit window from the head
    // ==================================================
    always_comb begin
        dispatch_pkg::rob_idx_t idx;
        logic                   run;
        run = 1'b1;
        for (int k = 0; k < `NUM_LANES; k++) begin
            idx                 = head_q + dispatch_pkg::rob_idx_t'(k);
            run                 = run && busy_q[idx] && done_q[idx];  // Stops at first gap
            commit_o[k].valid   = run;
            commit_o[k].rd_arch = arch_q[idx];
            commit_o[k].rob_idx = idx;
            commit_o[k].data    = data_q[idx];
        end
    end

    // Control bits
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
            done_q <= '0;
            head_q <= '0;
        end else begin
            for (int k = 0; k < `NUM_LANES; k++) begin
                if (commit_o[k].valid) begin
                    busy_q[commit_o[k].rob_idx] <= 1'b0;            // done_q kept for late reads
                    head_q <= commit_o[k].rob_idx + 1'b1;           // Last retired wins
                end
                if (cdb_i[k].valid) begin
                    done_q[cdb_i[k].rob_idx] <= 1'b1;
                end
                if (alloc_fire_i[k]) begin
                    busy_q[alloc_i[k].rd_rob] <= 1'b1;
                    done_q[alloc_i[k].rd_rob] <= 1'b0;
                end
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < `NUM_LANES; k++) begin
            if (alloc_fire_i[k]) begin
                arch_q[alloc_i[k].rd_rob] <= alloc_i[k].rd_arch;
                prod_q[alloc_i[k].rd_rob] <= dispatch_pkg::tag_t'(k);
            end
            if (cdb_i[k].valid) begin
                data_q[cdb_i[k].rob_idx] <= cdb_i[k].data;  // Channel k only carries lane k
            end
        end
    end

    // Issue stage must not reuse an entry before it retires
    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_alloc_chk
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
            alloc_fire_i[l] |-> !busy_q[alloc_i[l].rd_rob])
            else $error("ROB lane %0d allocated busy entry %0d", l, alloc_i[l].rd_rob);
    end

endmodule

/* hw/arch_reg_file.sv */
`timescale 1ns/1ps

`include "dispatch_params.svh"

module arch_reg_file (
    input  logic                                         clk_i,
    input  logic                                         arst_n_i,
    input  dispatch_pkg::arch_addr_t [2*`NUM_LANES-1:0]  rd_addr_i,
    output dispatch_pkg::data_t      [2*`NUM_LANES-1:0]  rd_data_o,
    input  dispatch_pkg::commit_t    [`NUM_LANES-1:0]    wr_i
);

    localparam int NUM_REGS = 2 ** `ARCH_ADDR_W;

    dispatch_pkg::data_t regs_q [NUM_REGS];

    // Async reads, x0 stays at its reset zero
    always_comb begin
        for (int p = 0; p < 2*`NUM_LANES; p++) begin
            rd_data_o[p] = regs_q[rd_addr_i[p]];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // Ascending order so the higher lane wins on a clash
            for (int k = 0; k < `NUM_LANES; k++) begin
                if (wr_i[k].valid && wr_i[k].rd_arch != '0) begin   // x0 ignores writes
                    regs_q[wr_i[k].rd_arch] <= wr_i[k].data;
                end
            end
        end
    end

endmodule

/* hw/dispatch_pkg.sv */
`include "dispatch_params.svh"

package dispatch_pkg;

    // ==================================================
    // Vector types
    // ==================================================
    typedef logic [`DATA_WIDTH-1:0]  data_t;
    typedef logic [`ARCH_ADDR_W-1:0] arch_addr_t;
    typedef logic [`ROB_IDX_W-1:0]   rob_idx_t;
    typedef logic [`ROB_IDX_W:0]     phys_addr_t;   // MSB set means ROB
    typedef logic [`TAG_W-1:0]       tag_t;         // Producer lane or TAG_READY
    typedef logic [`ALU_OP_W-1:0]    alu_op_t;

    // ==================================================
    // Bus structs
    // ==================================================
    typedef struct packed {
        tag_t  tag;
        data_t data;
    } operand_t;

    typedef struct packed {
        logic       valid;
        alu_op_t    alu_op;
        logic       use_imm;    // imm replaces operand B
        data_t      imm;
        phys_addr_t src_a;
        phys_addr_t src_b;
        rob_idx_t   rd_rob;     // Destination ROB entry
        arch_addr_t rd_arch;
    } dispatch_req_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        data_t    op_a;
        data_t    op_b;
        rob_idx_t rob_idx;
    } exec_req_t;

    typedef struct packed {
        logic     valid;        // One-cycle strobe
        rob_idx_t rob_idx;
        data_t    data;
    } cdb_t;

    typedef struct packed {
        logic       valid;
        arch_addr_t rd_arch;
        rob_idx_t   rob_idx;
        data_t      data;
    } commit_t;

    // Reservation station entry
    typedef enum logic [1:0] {FREE, WAIT, READY} rs_state_e;

    typedef struct packed {
        alu_op_t  alu_op;
        rob_idx_t rob_idx;      // Destination
        operand_t a;
        operand_t b;
        rob_idx_t wait_a;       // ROB entry each operand snoops for
        rob_idx_t wait_b;
    } rs_entry_t;

endpackage

/* include/dispatch_params.svh */
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// ==================================================
// Datapath and lanes
// ==================================================
`define DATA_WIDTH   32
`define NUM_LANES    3                  // Dispatch lanes and CDB channels

// Reorder buffer
`define ROB_DEPTH    32
`define ROB_IDX_W    5

`define ARCH_ADDR_W  5                  // x0..x31

// Producer tags
`define TAG_W        3
`define TAG_READY    {(`TAG_W){1'b1}}   // Data already present

`define ALU_OP_W     4                  // Opaque to this stage

`define RS_DEPTH     2                  // Entries per station

`endif
